/* list.f */
logic/glb_param_pkg.sv
logic/glb_type_pkg.sv
logic/glb_mem_if.sv
logic/glb_bank_sram_gen.sv
logic/glb_bank_memory.sv
logic/glb_req_front.sv
logic/glb_read_return.sv
logic/glb_bank_top.sv
dv/glb_bank_chk.sv
dv/glb_bank_tb.sv

/* dv/glb_bank_tb.sv */
// ################################################
// Testbench of one global buffer bank. Runs a table
// of host commands through the four-phase command
// channel and checks every read response. Response
// acknowledges are delayed by an LFSR.
// ################################################

module glb_bank_tb
    import glb_type_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 100;  // Upper bound for every handshake wait
    localparam int NUM_CMDS       = 10;
    localparam int HOLD_CYCLES    = 8;    // Extra rsp_ack delay while a read is held back

    typedef struct packed {
        logic       is_read;   // Read when high, write when low
        logic       defer;     // Keep the response pending while the next command runs
        bank_addr_t addr;
        bank_data_t data;
        bank_mask_t mask;
        bank_data_t exp_word;  // Expected read word from the merge rule
    } cmd_entry_t;

    logic       clk;
    logic       reset;
    logic       cmd_req;
    logic       cmd_wen;
    bank_addr_t cmd_addr;
    bank_data_t cmd_data;
    bank_mask_t cmd_bit_sel;
    logic       cmd_ack;
    logic       rsp_req;
    logic       rsp_ack;
    bank_data_t rsp_data;

    logic [15:0] lfsr_state = 16'd12767;  // Seed of the acknowledge delay
    time         ack_time;                 // When cmd_ack was last seen high
    time         release_time;             // When the last response handshake closed
    logic        rsp_pending;
    bank_data_t  pending_word;

    // ################################################
    // Command table
    // ################################################
    cmd_entry_t cmd_table [NUM_CMDS] = '{
        // Full write, then read back at the same address
        '{1'b0, 1'b0, 12'h010, 64'h0123_4567_89AB_CDEF, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0},
        '{1'b1, 1'b0, 12'h010, 64'h0, 64'h0, 64'h0123_4567_89AB_CDEF},
        // Partial write merges into every other byte, read through offset 3
        '{1'b0, 1'b0, 12'h010, 64'hFFFF_FFFF_0000_0000, 64'h00FF_00FF_00FF_00FF, 64'h0},
        '{1'b1, 1'b0, 12'h013, 64'h0, 64'h0, 64'h01FF_45FF_8900_CD00},
        // A run of writes with no response
        '{1'b0, 1'b0, 12'h7F9, 64'hDEAD_BEEF_CAFE_F00D, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0},
        '{1'b0, 1'b0, 12'h020, 64'h1111_2222_3333_4444, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0},
        '{1'b0, 1'b0, 12'h028, 64'h5555_6666_7777_8888, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0},
        // First read is held while the second one is issued
        '{1'b1, 1'b1, 12'h7FE, 64'h0, 64'h0, 64'hDEAD_BEEF_CAFE_F00D},
        '{1'b1, 1'b0, 12'h020, 64'h0, 64'h0, 64'h1111_2222_3333_4444},
        '{1'b1, 1'b0, 12'h02F, 64'h0, 64'h0, 64'h5555_6666_7777_8888}
    };

    glb_bank_top i_glb_bank_top (
        .clk         (clk),
        .reset       (reset),
        .cmd_req     (cmd_req),
        .cmd_wen     (cmd_wen),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .cmd_bit_sel (cmd_bit_sel),
        .cmd_ack     (cmd_ack),
        .rsp_req     (rsp_req),
        .rsp_ack     (rsp_ack),
        .rsp_data    (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // ################################################
    // Error handling and compares
    // ################################################
    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_problem(input string reason);
        $display("%s", reason);
        stop_on_error();
    endtask

    task automatic report_timeout(input string what);
        report_problem($sformatf("Timeout at %0t while waiting for %s", $time, what));
    endtask

    task automatic check_data(input string name, input bank_data_t got, input bank_data_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    // A failed handshake assertion in the bound checker ends the run at once
    always @(i_glb_bank_top.i_glb_bank_chk.error_count) begin
        if (i_glb_bank_top.i_glb_bank_chk.error_count != 0) begin
            report_problem("A handshake assertion failed in the bound checker");
        end
    end

    // Three LFSR bits give a delay of 0 to 7 cycles
    function automatic int next_delay();
        int d;
        d = 0;
        repeat (3) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            d = (d << 1) | int'(lfsr_state[0]);
        end
        return d;
    endfunction

    // ################################################
    // Host handshake tasks
    // ################################################
    task automatic send_cmd(input cmd_entry_t e, input logic quiet);
        int n;
        @(posedge clk);
        #1;
        cmd_req     = 1'b1;  // Payload is held until ack
        cmd_wen     = !e.is_read;
        cmd_addr    = e.addr;
        cmd_data    = e.data;
        cmd_bit_sel = e.mask;
        n = 0;
        while (cmd_ack !== 1'b1) begin
            @(posedge clk);
            #1;
            if (quiet) check_level("rsp_req", rsp_req, 1'b0);  // Writes never answer
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("cmd_ack to rise");
        end
        ack_time = $time;
        cmd_req  = 1'b0;
        n = 0;
        while (cmd_ack !== 1'b0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("cmd_ack to fall");
        end
    endtask

    task automatic collect_rsp(input bank_data_t exp, input int extra);
        int n;
        int delay;
        n = 0;
        while (rsp_req !== 1'b1) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("rsp_req to rise");
        end
        check_data("rsp_data", rsp_data, exp);
        delay = next_delay() + extra;
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        rsp_ack = 1'b1;
        n = 0;
        while (rsp_req !== 1'b0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("rsp_req to fall");
        end
        rsp_ack      = 1'b0;
        release_time = $time;
    endtask

    // ################################################
    // Main sequence
    // ################################################
    initial begin
        int idx;
        reset        = 1'b1;
        cmd_req      = 1'b0;
        cmd_wen      = 1'b0;
        cmd_addr     = '0;
        cmd_data     = '0;
        cmd_bit_sel  = '0;
        rsp_ack      = 1'b0;
        rsp_pending  = 1'b0;
        pending_word = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        check_level("cmd_ack", cmd_ack, 1'b0);  // Both channels idle out of reset
        check_level("rsp_req", rsp_req, 1'b0);

        for (idx = 0; idx < NUM_CMDS; idx++) begin
            if (rsp_pending) begin
                // The held response must close before this command is acknowledged
                fork
                    send_cmd(cmd_table[idx], 1'b0);
                    collect_rsp(pending_word, HOLD_CYCLES);
                join
                rsp_pending = 1'b0;
                if (ack_time <= release_time) begin
                    report_problem("A read was acknowledged while a response was still held");
                end
            end else begin
                send_cmd(cmd_table[idx], !cmd_table[idx].is_read);
            end
            if (cmd_table[idx].is_read && cmd_table[idx].defer) begin
                rsp_pending  = 1'b1;
                pending_word = cmd_table[idx].exp_word;
            end else if (cmd_table[idx].is_read) begin
                collect_rsp(cmd_table[idx].exp_word, 0);
            end
        end

        repeat (2) @(posedge clk);
        #1;
        $display("test passed");
        $finish;
    end

endmodule : glb_bank_tb

/* dv/glb_bank_chk.sv */
// ################################################
// Handshake and access pulse assertions, bound to
// the bank top level.
// ################################################

module glb_bank_chk
    import glb_type_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       ren,
    input logic       wen,
    input logic       cmd_req,
    input logic       cmd_ack,
    input logic       rsp_req,
    input logic       rsp_ack,
    input bank_data_t rsp_data
);

    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0;  // Failed assertion count

    // Read and write share the single SRAM port
    a_access_excl: assert property (@(posedge clk) disable iff (reset) !(ren && wen))
        else begin
            $error("ren and wen high together");
            error_count++;
        end

    a_ren_pulse: assert property (@(posedge clk) disable iff (reset) ren |=> !ren)
        else begin
            $error("ren longer than one cycle");
            error_count++;
        end

    a_wen_pulse: assert property (@(posedge clk) disable iff (reset) wen |=> !wen)
        else begin
            $error("wen longer than one cycle");
            error_count++;
        end

    // The host may sample rsp_data at any point before it acknowledges
    a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        (rsp_req && !rsp_ack) |=> $stable(rsp_data))
        else begin
            $error("rsp_data changed during the response handshake");
            error_count++;
        end

    a_ack_hold: assert property (@(posedge clk) disable iff (reset)
        (cmd_ack && cmd_req) |=> cmd_ack)
        else begin
            $error("cmd_ack fell while cmd_req was high");
            error_count++;
        end

endmodule : glb_bank_chk

bind glb_bank_top glb_bank_chk i_glb_bank_chk (
    .clk      (clk),
    .reset    (reset),
    .ren      (i_glb_mem_if.ren),
    .wen      (i_glb_mem_if.wen),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .rsp_req  (rsp_req),
    .rsp_ack  (rsp_ack),
    .rsp_data (rsp_data)
);

/* logic/glb_bank_top.sv */
// ################################################
// Top level of one global buffer bank. Host command
// and response channels are plain four-phase ports,
// the internal blocks share the memory interface.
// ################################################

module glb_bank_top
    import glb_type_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cmd_req,      // Command request
    input  logic       cmd_wen,      // Write when high
    input  bank_addr_t cmd_addr,     // Byte address
    input  bank_data_t cmd_data,     // Write data
    input  bank_mask_t cmd_bit_sel,  // Bit write mask
    output logic       cmd_ack,      // Command acknowledge
    output logic       rsp_req,      // Response request
    input  logic       rsp_ack,      // Response acknowledge
    output bank_data_t rsp_data      // Response word
);

    glb_mem_if i_glb_mem_if ();  // Access bus between the three blocks

    // Producer of the accesses
    glb_req_front i_glb_req_front (
        .clk         (clk),
        .reset       (reset),
        .cmd_req     (cmd_req),
        .cmd_wen     (cmd_wen),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .cmd_bit_sel (cmd_bit_sel),
        .cmd_ack     (cmd_ack),
        .mem         (i_glb_mem_if.front)
    );

    // Storage
    glb_bank_memory i_glb_bank_memory (
        .clk   (clk),
        .reset (reset),
        .mem   (i_glb_mem_if.mem)
    );

    // Consumer of the read words
    glb_read_return i_glb_read_return (
        .clk      (clk),
        .reset    (reset),
        .mem      (i_glb_mem_if.ret),
        .rsp_req  (rsp_req),
        .rsp_ack  (rsp_ack),
        .rsp_data (rsp_data)
    );

endmodule : glb_bank_top

/* logic/glb_read_return.sv */
// ################################################
// Read-return unit. Captures the word that the bank
// memory returns for each read and offers it to the
// host over the four-phase response handshake.
// busy stays high from capture until the host has
// released the handshake.
// ################################################

module glb_read_return
    import glb_type_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    glb_mem_if.ret     mem,
    output logic       rsp_req,   // Response request to the host
    input  logic       rsp_ack,   // Host acknowledge
    output bank_data_t rsp_data   // Response word
);

    return_state_e state;   // Response machine state
    logic          ren_d1;  // High in the cycle that carries read data
    bank_data_t    hold_q;  // Captured read word

    // ################################################
    // Response handshake machine
    // ################################################
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= RET_IDLE;
            ren_d1   <= 1'b0;
            rsp_req  <= 1'b0;
            mem.busy <= 1'b0;
        end else begin
            ren_d1 <= mem.ren;  // Bank memory answers one cycle after ren
            case (state)
                RET_IDLE: begin
                    if (ren_d1) begin
                        state    <= RET_REQ;  // Word is captured at this edge
                        mem.busy <= 1'b1;
                    end
                end
                RET_REQ: begin
                    if (!rsp_req) begin
                        rsp_req <= 1'b1;  // Offer the word one cycle after capture
                    end else if (rsp_ack) begin
                        state   <= RET_RELEASE;
                        rsp_req <= 1'b0;
                    end
                end
                RET_RELEASE: begin
                    if (!rsp_ack) begin
                        state    <= RET_IDLE;  // Handshake back to zero, path is free
                        mem.busy <= 1'b0;
                    end
                end
                default: begin
                    state    <= RET_IDLE;
                    rsp_req  <= 1'b0;
                    mem.busy <= 1'b0;
                end
            endcase
        end
    end

    // Only one read is in flight, so the capture never overwrites a held word
    always_ff @(posedge clk) begin
        if (ren_d1 && (state == RET_IDLE)) begin
            hold_q <= mem.data_out;
        end
    end

    assign rsp_data = hold_q;  // Stable for the whole handshake

endmodule : glb_read_return

/* logic/glb_req_front.sv */
// ################################################
// Command front end. Runs the four-phase command
// handshake with the host, latches the command and
// issues one access pulse per command. Reads are
// acknowledged once the read-return unit holds the
// response, so only one read is ever outstanding.
// ################################################

module glb_req_front
    import glb_type_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cmd_req,      // Host command request
    input  logic       cmd_wen,      // High for a write, low for a read
    input  bank_addr_t cmd_addr,     // Byte address
    input  bank_data_t cmd_data,     // Write data
    input  bank_mask_t cmd_bit_sel,  // Bit write mask
    output logic       cmd_ack,      // Command acknowledge
    glb_mem_if.front   mem
);

    front_state_e state;     // Command machine state
    logic         op_wen_q;  // Latched operation, high for a write
    bank_addr_t   addr_q;    // Latched address
    bank_data_t   data_q;    // Latched write data
    bank_mask_t   mask_q;    // Latched write mask
    logic         accept;    // A command is taken this cycle

    // Reads wait for the response path to be free, writes may overlap a held response
    assign accept = (state == FRONT_IDLE) && cmd_req && (cmd_wen || !mem.busy);

    // ################################################
    // Command handshake machine
    // ################################################
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= FRONT_IDLE;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                FRONT_IDLE: begin
                    if (accept) begin
                        state <= FRONT_ISSUE;  // Pulse goes out on the next cycle
                    end
                end
                FRONT_ISSUE: begin
                    if (op_wen_q) begin
                        state   <= FRONT_ACK;  // Write is done at this edge
                        cmd_ack <= 1'b1;
                    end else begin
                        state <= FRONT_WAIT_READ;  // Wait for the response to be held
                    end
                end
                FRONT_WAIT_READ: begin
                    if (mem.busy) begin
                        state   <= FRONT_ACK;  // Response captured, release the host
                        cmd_ack <= 1'b1;
                    end
                end
                FRONT_ACK: begin
                    if (!cmd_req) begin
                        state   <= FRONT_IDLE;  // Four-phase return to zero
                        cmd_ack <= 1'b0;
                    end
                end
                default: begin
                    state   <= FRONT_IDLE;
                    cmd_ack <= 1'b0;
                end
            endcase
        end
    end

    // ################################################
    // Command payload
    // ################################################
    always_ff @(posedge clk) begin
        if (accept) begin
            op_wen_q <= cmd_wen;
            addr_q   <= cmd_addr;
            data_q   <= cmd_data;
            mask_q   <= cmd_bit_sel;
        end
    end

    // One pulse in the issue state, only one of the two is ever high
    assign mem.ren     = (state == FRONT_ISSUE) && !op_wen_q;
    assign mem.wen     = (state == FRONT_ISSUE) && op_wen_q;
    assign mem.addr    = addr_q;
    assign mem.data_in = data_q;
    assign mem.bit_sel = mask_q;

endmodule : glb_req_front

/* logic/glb_bank_memory.sv */
// ################################################
// Bank memory. Maps byte addresses to word addresses,
// drives the SRAM with active-low controls and keeps
// the last read word on data_out until the next read.
// Read data shows up one cycle after the ren pulse.
// ################################################

module glb_bank_memory
    import glb_param_pkg::*;
    import glb_type_pkg::*;
(
    input  logic clk,
    input  logic reset,
    glb_mem_if.mem mem
);

    // ################################################
    // SRAM side signals
    // ################################################
    logic       sram_cen;       // High for any access
    logic       sram_wen;       // High for a write
    sram_addr_t sram_addr;      // Word address with the byte offset dropped
    bank_data_t sram_data_out;  // Raw SRAM output
    logic       ren_d1;         // Read pulse delayed to the data cycle
    bank_data_t data_out_d1;    // Word shown on the previous cycle

    assign sram_cen  = mem.ren | mem.wen;
    assign sram_wen  = mem.wen;
    assign sram_addr = mem.addr[BANK_ADDR_WIDTH-1:BANK_ADDR_BYTE_OFFSET];  // Byte bits are ignored

    glb_bank_sram_gen #(
        .DATA_WIDTH (BANK_DATA_WIDTH),
        .ADDR_WIDTH (SRAM_ADDR_WIDTH)
    ) i_glb_bank_sram_gen (
        .CLK  (clk),
        .CEB  (~sram_cen),      // Macro wants low active enables
        .WEB  (~sram_wen),
        .A    (sram_addr),
        .D    (mem.data_in),
        .BWEB (~mem.bit_sel),   // Mask uses 1 for write, the macro uses 0
        .Q    (sram_data_out)
    );

    // ################################################
    // Output hold
    // ################################################
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ren_d1      <= 1'b0;
            data_out_d1 <= '0;
        end else begin
            ren_d1      <= mem.ren;       // Marks the cycle with fresh SRAM data
            data_out_d1 <= mem.data_out;  // Remember what was shown
        end
    end

    // A fresh read wins, otherwise the last word stays on the bus
    assign mem.data_out = ren_d1 ? sram_data_out : data_out_d1;

endmodule : glb_bank_memory

/* logic/glb_bank_sram_gen.sv */
// ################################################
// Behavioral single-port SRAM with macro-style pins.
// All controls are active low, BWEB masks writes per
// bit. Q is registered on reads and holds otherwise.
// ################################################

module glb_bank_sram_gen #(
    parameter int DATA_WIDTH = 64,  // Word width
    parameter int ADDR_WIDTH = 9    // Word address width
) (
    input  logic                  CLK,
    input  logic                  CEB,   // Chip enable, low active
    input  logic                  WEB,   // Write enable, low active
    input  logic [ADDR_WIDTH-1:0] A,     // Word address
    input  logic [DATA_WIDTH-1:0] D,     // Write data
    input  logic [DATA_WIDTH-1:0] BWEB,  // Bit write enables, low active
    output logic [DATA_WIDTH-1:0] Q      // Read data
);

    // ################################################
    // Storage array
    // ################################################
    logic [DATA_WIDTH-1:0] mem_array [2**ADDR_WIDTH];  // Contents are undefined after power up

    // Write and read share the one port, the chip enable gates both
    always_ff @(posedge CLK) begin
        if (!CEB) begin
            if (!WEB) begin
                // Keep the bits whose enable is high and take D where it is low
                mem_array[A] <= (mem_array[A] & BWEB) | (D & ~BWEB);
            end else begin
                Q <= mem_array[A];  // Registered read output
            end
        end
    end

endmodule : glb_bank_sram_gen

/* logic/glb_mem_if.sv */
// ################################################
// Memory access bundle between the command front
// end, the bank memory and the read-return unit.
// Each block connects through its own modport.
// ################################################

interface glb_mem_if
    import glb_type_pkg::*;
();

    logic       ren;       // One-cycle read pulse
    logic       wen;       // One-cycle write pulse
    bank_addr_t addr;      // Byte address of the access
    bank_data_t data_in;   // Write data
    bank_mask_t bit_sel;   // Bit write mask
    bank_data_t data_out;  // Last read word
    logic       busy;      // A read response is still pending

    // Issues accesses and holds off reads while a response is pending
    modport front (
        output ren, wen, addr, data_in, bit_sel,
        input  busy
    );

    // Performs the accesses on the SRAM
    modport mem (
        input  ren, wen, addr, data_in, bit_sel,
        output data_out
    );

    // Picks up read words and reports the pending response
    modport ret (
        input  ren, data_out,
        output busy
    );

endinterface : glb_mem_if

/* logic/glb_type_pkg.sv */
// ################################################
// Shared types of the bank design: data, mask and
// address vectors plus the states of the command
// and response handshake machines.
// ################################################

package glb_type_pkg;

    import glb_param_pkg::*;

    // ################################################
    // Vector types
    // ################################################
    typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;  // One bank word
    typedef logic [BANK_DATA_WIDTH-1:0] bank_mask_t;  // Bit write mask, a 1 writes the bit
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;  // Byte address in the bank
    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;  // Word address in the SRAM

    // ################################################
    // Handshake machine states
    // ################################################
    typedef enum logic [1:0] {
        FRONT_IDLE,       // Waiting for a command
        FRONT_ISSUE,      // Access pulse to the bank memory
        FRONT_ACK,        // Command acknowledged, waiting for req low
        FRONT_WAIT_READ   // Read issued, waiting for the response unit
    } front_state_e;

    typedef enum logic [1:0] {
        RET_IDLE,         // No response held
        RET_REQ,          // Response offered to the host
        RET_RELEASE       // Waiting for the host to drop ack
    } return_state_e;

endpackage : glb_type_pkg

/* logic/glb_param_pkg.sv */
// ################################################
// Geometry constants of one global buffer bank.
// Import this package wherever widths or sizes of
// the bank words and addresses are needed.
// ################################################

package glb_param_pkg;

    // ################################################
    // Word and byte address geometry
    // ################################################
    localparam int BANK_DATA_WIDTH       = 64;  // Bits in one bank word
    localparam int BANK_ADDR_WIDTH       = 12;  // Byte address bits inside the bank
    localparam int BANK_ADDR_BYTE_OFFSET = 3;   // Low bits that pick a byte in a word

    // ################################################
    // SRAM array geometry
    // ################################################
    // The word count follows from the byte address space
    localparam int SRAM_DEPTH      = 2 ** (BANK_ADDR_WIDTH - BANK_ADDR_BYTE_OFFSET);
    localparam int SRAM_ADDR_WIDTH = $clog2(SRAM_DEPTH);  // Word address bits

endpackage : glb_param_pkg
